// File: bench/decodeStageTb.sv
module decodeStageTb
  import cpuDecodePkg::*;
();

  localparam int RANDOM_COUNT    = 300;
  localparam int DIRECTED_CYCLES = 320;  // upper bound of directed cycles

  // where a register index comes from
  typedef enum logic [2:0] {noReg, fieldX, fieldY, fieldZ, fixedIh, fixedSp, fixedRa} fieldSelT;

  typedef struct packed {
    fieldSelT s;
    fieldSelT m;
    fieldSelT t;
  } routeT;

  typedef struct packed {
    logic        valid;
    logic [15:0] instrWord;
  } pendingT;

  logic        clk;
  logic        rst;
  logic [15:0] instruction;
  logic        instrValid;
  logic        wbEn;
  regIndexT    wbIndex;
  logic [15:0] wbData;
  operandT     operands;

  logic [15:0] modelRegs [NUM_REGS];
  pendingT     inFlight [$];
  operandT     expectQ [$];
  operandT     heldExpect;
  logic        holding;
  int          checkCount;
  int          errorCount;

  decodeStage u_decodeStage (
    .clk         (clk),
    .rst         (rst),
    .instruction (instruction),
    .instrValid  (instrValid),
    .wbEn        (wbEn),
    .wbIndex     (wbIndex),
    .wbData      (wbData),
    .operands    (operands)
  );

  always #5 clk = ~clk;

  function automatic logic [15:0] encode(logic [4:0] op, logic [2:0] x, logic [2:0] y,
                                         logic [4:0] low);
    return {op, x, y, low};
  endfunction

  function automatic regIndexT fieldIndex(logic [15:0] instrWord, fieldSelT sel);
    case (sel)
      fieldX:  return {1'b0, instrWord[10:8]};
      fieldY:  return {1'b0, instrWord[7:5]};
      fieldZ:  return {1'b0, instrWord[4:2]};
      fixedIh: return REG_IH;
      fixedSp: return REG_SP;
      fixedRa: return REG_RA;
      default: return 4'd0;
    endcase
  endfunction

  // register routing table, S then M then T
  function automatic decodedT routeRegisters(logic [15:0] instrWord, logic valid);
    routeT   r;
    decodedT d;
    r = '{noReg, noReg, noReg};
    case (instrWord[15:11])
      5'b00000: r = '{fixedSp, noReg, fieldX};                       // addsp3
      5'b00100, 5'b00101, 5'b01010, 5'b01011, 5'b01110: r = '{fieldX, noReg, noReg};
      5'b00110, 5'b01111: r = '{fieldY, noReg, fieldX};              // shifts, move
      5'b01000: r = '{fieldX, noReg, fieldY};                        // addiu3
      5'b01001: r = '{fieldX, noReg, fieldX};                        // addiu
      5'b01100:
        case (instrWord[10:8])
          3'b010:  r = '{fixedRa, fixedSp, noReg};                   // sw_rs
          3'b011:  r = '{fixedSp, noReg, fixedSp};                   // addsp
          3'b100:  r = '{fieldY, noReg, fixedSp};                    // mtsp
          default: ;
        endcase
      5'b01101: r = '{noReg, noReg, fieldX};                         // li
      5'b10010: r = '{noReg, fixedSp, fieldX};                       // lw_sp
      5'b10011: r = '{noReg, fieldX, fieldY};                        // lw
      5'b11010: r = '{fieldX, fixedSp, noReg};                       // sw_sp
      5'b11011: r = '{fieldY, fieldX, noReg};                        // sw
      5'b11100: r = '{fieldX, fieldY, fieldZ};                       // addu, subu
      5'b11101:
        case (instrWord[4:0])
          5'b00000:
            case (instrWord[7:5])
              3'b000:  r = '{fieldX, noReg, noReg};                  // jr
              3'b010:  r = '{noReg, noReg, fieldX};                  // mfpc
              3'b110:  r = '{fieldX, noReg, fixedRa};                // jalr
              default: ;
            endcase
          5'b00010, 5'b00011: r = '{fieldX, fieldY, noReg};          // slt, sltu
          5'b00100, 5'b00110, 5'b00111: r = '{fieldY, fieldX, fieldY};
          5'b01010: r = '{fieldY, fieldX, noReg};                    // cmp
          5'b01011, 5'b01111: r = '{fieldY, noReg, fieldX};          // neg, not
          5'b01100, 5'b01101, 5'b01110: r = '{fieldY, fieldX, fieldX};
          default: ;
        endcase
      5'b11110:
        r = instrWord[0] ? routeT'{fieldX, noReg, fixedIh}   // mtih
                         : routeT'{fixedIh, noReg, fieldX};  // mfih
      default: ;
    endcase
    d.op     = majorOpT'(instrWord[15:11]);
    d.regS   = fieldIndex(instrWord, r.s);
    d.regM   = fieldIndex(instrWord, r.m);
    d.regT   = fieldIndex(instrWord, r.t);
    d.writeT = (r.t != noReg);
    d.valid  = valid;
    return d;
  endfunction

  function automatic logic [15:0] extendImmediate(logic [15:0] instrWord);
    case (instrWord[15:11])
      5'b00000, 5'b00100, 5'b00101, 5'b01001, 5'b01010, 5'b01110, 5'b10010, 5'b11010:
        return 16'($signed(instrWord[7:0]));
      5'b01101, 5'b01011: return {8'd0, instrWord[7:0]};            // li, sltui
      5'b01000: return 16'($signed(instrWord[3:0]));
      5'b10011, 5'b11011: return 16'($signed(instrWord[4:0]));
      5'b00010: return 16'($signed(instrWord[10:0]));
      5'b00110: return (instrWord[4:2] == 3'd0) ? 16'd8 : {13'd0, instrWord[4:2]};
      5'b01100:
        if (instrWord[10:8] == 3'b000 || instrWord[10:8] == 3'b001 || instrWord[10:8] == 3'b011)
          return 16'($signed(instrWord[7:0]));
      default: ;
    endcase
    return 16'd0;
  endfunction

  // model registers already hold the write-back of the registering edge
  function automatic operandT predictOperands(logic [15:0] instrWord, logic valid);
    logic [15:0] effective;
    operandT     e;
    effective   = valid ? instrWord : NOP_INSTR;
    e.decoded   = routeRegisters(effective, valid);
    e.valueS    = modelRegs[e.decoded.regS];
    e.valueM    = modelRegs[e.decoded.regM];
    e.immediate = extendImmediate(effective);
    return e;
  endfunction

  function automatic logic [15:0] readerFor(regIndexT r);
    if (r < 4'd8)
      return encode(5'b11100, r[2:0], r[2:0], 5'b00000);  // addu reads r on S and M
    else if (r == REG_IH)
      return encode(5'b11110, 3'd0, 3'd0, 5'b00000);      // mfih
    else if (r == REG_SP)
      return encode(5'b11010, 3'd1, 3'd0, 5'b00100);      // sw_sp, sp on M
    else
      return encode(5'b01100, 3'b010, 3'd0, 5'b00011);    // sw_rs
  endfunction

  task automatic driveCycle(logic [15:0] instrWord, logic valid, logic wbOn, regIndexT wbIdx,
                            logic [15:0] wbVal);
    pendingT entry;
    pendingT oldest;
    @(negedge clk);
    instruction = instrWord;
    instrValid  = valid;
    wbEn        = wbOn;
    wbIndex     = wbIdx;
    wbData      = wbVal;
    if (wbOn)
      modelRegs[wbIdx] = wbVal;  // lands at the coming rising edge
    entry.valid     = valid;
    entry.instrWord = instrWord;
    inFlight.push_back(entry);
    if (inFlight.size() > 2)
    begin
      oldest = inFlight.pop_front();
      expectQ.push_back(predictOperands(oldest.instrWord, oldest.valid));
    end
  endtask

  task automatic issue(logic [15:0] instrWord);
    driveCycle(instrWord, 1'b1, 1'b0, 4'd0, 16'd0);
  endtask

  task automatic idle();
    driveCycle(NOP_INSTR, 1'b0, 1'b0, 4'd0, 16'd0);
  endtask

  task automatic checkField(string name, logic [15:0] got, logic [15:0] want);
    checkCount++;
    if (got !== want)
    begin
      errorCount++;
      $display("Error: %s got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  task automatic checkOperands(operandT exp);
    checkField("operands.decoded.op", {11'd0, operands.decoded.op}, {11'd0, exp.decoded.op});
    checkField("operands.decoded.regS", {12'd0, operands.decoded.regS},
               {12'd0, exp.decoded.regS});
    checkField("operands.decoded.regM", {12'd0, operands.decoded.regM},
               {12'd0, exp.decoded.regM});
    checkField("operands.decoded.regT", {12'd0, operands.decoded.regT},
               {12'd0, exp.decoded.regT});
    checkField("operands.decoded.writeT", {15'd0, operands.decoded.writeT},
               {15'd0, exp.decoded.writeT});
    checkField("operands.decoded.valid", {15'd0, operands.decoded.valid},
               {15'd0, exp.decoded.valid});
    checkField("operands.valueS", operands.valueS, exp.valueS);
    checkField("operands.valueM", operands.valueM, exp.valueM);
    checkField("operands.immediate", operands.immediate, exp.immediate);
  endtask

  // record seen here was registered at the previous rising edge
  always @(posedge clk)
  begin
    if (holding)
      checkOperands(heldExpect);
    holding = 1'b0;
    if (expectQ.size() > 0)
    begin
      heldExpect = expectQ.pop_front();
      holding    = 1'b1;
    end
  end

  initial
  begin
    #((DIRECTED_CYCLES + RANDOM_COUNT) * 10 + 1000);
    $display("watchdog expired before the test sequence finished");
    $display("TEST FAIL");
    $finish;
  end

  initial
  begin
    clk         = 1'b0;
    rst         = 1'b0;
    instruction = NOP_INSTR;
    instrValid  = 1'b0;
    wbEn        = 1'b0;
    wbIndex     = 4'd0;
    wbData      = 16'd0;
    holding     = 1'b0;
    checkCount  = 0;
    errorCount  = 0;
    void'($urandom(32'h8b2f));
    for (int i = 0; i < NUM_REGS; i++)
      modelRegs[i] = 16'd0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    checkCount++;
    if (operands !== '0)
    begin
      errorCount++;
      $display("Error: operands after reset got %h expected 0", operands);
    end

    // every register reads zero out of reset
    for (int i = 0; i < NUM_REGS; i++)
      issue(readerFor(4'(i)));

    // full decode table, listed and unlisted encodings
    for (int op = 0; op < 32; op++)
      issue(encode(5'(op), 3'd3, 3'd5, 5'b10110));
    for (int x = 0; x < 8; x++)
      issue(encode(5'b01100, 3'(x), 3'd6, 5'b01001));
    for (int f = 0; f < 32; f++)
      issue(encode(5'b11101, 3'd2, 3'd7, 5'(f)));
    for (int y = 0; y < 8; y++)
      issue(encode(5'b11101, 3'd4, 3'(y), 5'd0));
    issue(encode(5'b11110, 3'd1, 3'd0, 5'd1));   // mtih
    issue(encode(5'b11110, 3'd1, 3'd0, 5'd0));   // mfih

    // immediate classes
    for (int op = 0; op < 32; op++)
      repeat (4) issue({5'(op), 11'($urandom())});
    issue(encode(5'b00110, 3'd1, 3'd2, 5'b00000));  // shift by eight
    issue({5'b00010, 11'h400});
    issue(encode(5'b01000, 3'd1, 3'd2, 5'b01000));
    issue(encode(5'b10011, 3'd1, 3'd2, 5'b10000));
    issue(encode(5'b01101, 3'd1, 3'b100, 5'b00000));
    issue(encode(5'b01100, 3'b000, 3'b111, 5'b11111));

    // write every register, then read it back
    for (int i = 0; i < NUM_REGS; i++)
      driveCycle(NOP_INSTR, 1'b0, 1'b1, 4'(i), 16'($urandom()));
    for (int i = 0; i < NUM_REGS; i++)
      issue(readerFor(4'(i)));
    issue(encode(5'b01100, 3'b011, 3'd4, 5'b00001));  // addsp, sp on S
    issue(encode(5'b10010, 3'd2, 3'd0, 5'b00010));    // lw_sp

    // write-back at the edge that registers the reader
    for (int i = 0; i < NUM_REGS; i++)
    begin
      issue(readerFor(4'(i)));
      idle();
      driveCycle(NOP_INSTR, 1'b0, 1'b1, 4'(i), 16'($urandom()));
    end

    // back-to-back random stream
    repeat (RANDOM_COUNT)
      driveCycle(16'($urandom()), ($urandom() % 5) != 0, 1'($urandom()),
                 4'($urandom() % NUM_REGS), 16'($urandom()));

    repeat (3) idle();
    repeat (2) @(posedge clk);
    @(negedge clk);
    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// File: decodeStage.f
logic/cpuDecodePkg.sv
logic/instructionDecoder.sv
logic/immediateExtender.sv
logic/registerFile.sv
logic/operandFetch.sv
logic/decodeStage.sv
bench/decodeStageTb.sv

// File: logic/cpuDecodePkg.sv
package cpuDecodePkg;

  typedef logic [3:0] regIndexT;       // r0..r7 plus specials

  localparam regIndexT REG_IH = 4'd8;  // interrupt handler
  localparam regIndexT REG_SP = 4'd9;  // stack pointer
  localparam regIndexT REG_RA = 4'd10; // return address

  localparam int NUM_REGS = 11;

  localparam logic [15:0] NOP_INSTR = 16'h0800; // major 00001, rest zero

  // major opcode, bits 15:11 of the instruction word
  typedef enum logic [4:0] {
    addsp3   = 5'b00000,
    nop      = 5'b00001,
    b        = 5'b00010,
    beqz     = 5'b00100,
    bnez     = 5'b00101,
    shift    = 5'b00110,  // sll, srl, sra
    addiu3   = 5'b01000,
    addiu    = 5'b01001,
    slti     = 5'b01010,
    sltui    = 5'b01011,
    special  = 5'b01100,  // bteqz, btnez, sw_rs, addsp, mtsp
    li       = 5'b01101,
    cmpi     = 5'b01110,
    move     = 5'b01111,
    lwSp     = 5'b10010,
    lw       = 5'b10011,
    swSp     = 5'b11010,
    sw       = 5'b11011,
    adduSubu = 5'b11100,
    regOp    = 5'b11101,  // sub-table in bits 4:0
    ihOp     = 5'b11110,  // mfih, mtih
    intOp    = 5'b11111
  } majorOpT;

  typedef struct packed {
    majorOpT  op;
    regIndexT regS;    // first source
    regIndexT regM;    // second source
    regIndexT regT;    // destination
    logic     writeT;  // regT is meaningful
    logic     valid;
  } decodedT;

  typedef struct packed {
    decodedT     decoded;
    logic [15:0] valueS;
    logic [15:0] valueM;
    logic [15:0] immediate;
  } operandT;

endpackage

// File: logic/decodeStage.sv
module decodeStage
  import cpuDecodePkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] instruction,
  input  logic        instrValid,
  input  logic        wbEn,
  input  regIndexT    wbIndex,
  input  logic [15:0] wbData,
  output operandT     operands
);

  logic [15:0] instrReg;
  logic [15:0] immediate;
  logic [15:0] readS;
  logic [15:0] readM;
  decodedT     decoded;
  regIndexT    readIndexS;
  regIndexT    readIndexM;

  instructionDecoder u_instructionDecoder (
    .clk         (clk),
    .rst         (rst),
    .instruction (instruction),
    .instrValid  (instrValid),
    .instrReg    (instrReg),
    .decoded     (decoded)
  );

  immediateExtender u_immediateExtender (
    .instr     (instrReg),
    .immediate (immediate)
  );

  registerFile u_registerFile (
    .clk        (clk),
    .rst        (rst),
    .readIndexS (readIndexS),
    .readIndexM (readIndexM),
    .wbEn       (wbEn),
    .wbIndex    (wbIndex),
    .wbData     (wbData),
    .readS      (readS),
    .readM      (readM)
  );

  operandFetch u_operandFetch (
    .clk        (clk),
    .rst        (rst),
    .decoded    (decoded),
    .immediate  (immediate),
    .readS      (readS),
    .readM      (readM),
    .wbEn       (wbEn),
    .wbIndex    (wbIndex),
    .wbData     (wbData),
    .readIndexS (readIndexS),
    .readIndexM (readIndexM),
    .operands   (operands)
  );

endmodule

// File: logic/immediateExtender.sv
module immediateExtender
  import cpuDecodePkg::*;
(
  input  logic [15:0] instr,
  output logic [15:0] immediate
);

  majorOpT     opcode;
  logic [15:0] sext8;
  logic [15:0] zext8;
  logic [15:0] sext4;
  logic [15:0] sext5;
  logic [15:0] sext11;
  logic [15:0] shiftAmount;

  assign opcode = majorOpT'(instr[15:11]);

  assign sext8  = {{8{instr[7]}}, instr[7:0]};
  assign zext8  = {8'h00, instr[7:0]};
  assign sext4  = {{12{instr[3]}}, instr[3:0]};
  assign sext5  = {{11{instr[4]}}, instr[4:0]};
  assign sext11 = {{5{instr[10]}}, instr[10:0]};

  // shift field of zero encodes a shift by eight
  assign shiftAmount = (instr[4:2] == 3'b000) ? 16'd8 : {13'b0, instr[4:2]};

  always_comb
  begin
    immediate = '0;
    case (opcode)
      addsp3, beqz, bnez, addiu, slti, cmpi, lwSp, swSp:
        immediate = sext8;
      li, sltui:
        immediate = zext8;
      addiu3:
        immediate = sext4;
      lw, sw:
        immediate = sext5;
      b:
        immediate = sext11;
      shift:
        immediate = shiftAmount;
      special:
        case (instr[10:8])
          3'b000, 3'b001, 3'b011:  // bteqz, btnez, addsp
            immediate = sext8;
          default:
            immediate = '0;        // sw_rs, mtsp
        endcase
      default:
        immediate = '0;
    endcase
  end

endmodule

// File: logic/instructionDecoder.sv
module instructionDecoder
  import cpuDecodePkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] instruction,
  input  logic        instrValid,
  output logic [15:0] instrReg,
  output decodedT     decoded
);

  logic     validReg;
  majorOpT  opcode;
  regIndexT rx;
  regIndexT ry;
  regIndexT rz;
  regIndexT selS;
  regIndexT selM;
  regIndexT selT;
  logic     selW;

  assign opcode = majorOpT'(instrReg[15:11]);
  assign rx     = {1'b0, instrReg[10:8]};
  assign ry     = {1'b0, instrReg[7:5]};
  assign rz     = {1'b0, instrReg[4:2]};

  // first stage: capture the word and its strobe
  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      instrReg <= NOP_INSTR;
      validReg <= 1'b0;
    end
    else
    begin
      instrReg <= instrValid ? instruction : NOP_INSTR; // idle cycles decode as nop
      validReg <= instrValid;
    end
  end

  // register selection table
  always_comb
  begin
    selS = '0;
    selM = '0;
    selT = '0;
    selW = 1'b0;
    case (opcode)
      addsp3:
      begin
        selS = REG_SP;
        selT = rx;
        selW = 1'b1;
      end
      beqz, bnez, slti, sltui, cmpi:
        selS = rx;
      shift, move:
      begin
        selS = ry;
        selT = rx;
        selW = 1'b1;
      end
      addiu3:
      begin
        selS = rx;
        selT = ry;
        selW = 1'b1;
      end
      addiu:
      begin
        selS = rx;
        selT = rx;
        selW = 1'b1;
      end
      special:
        case (instrReg[10:8])
          3'b010:                  // sw_rs
          begin
            selS = REG_RA;
            selM = REG_SP;
          end
          3'b011:                  // addsp
          begin
            selS = REG_SP;
            selT = REG_SP;
            selW = 1'b1;
          end
          3'b100:                  // mtsp
          begin
            selS = ry;
            selT = REG_SP;
            selW = 1'b1;
          end
          default: ;               // bteqz, btnez read the T flag only
        endcase
      li:
      begin
        selT = rx;
        selW = 1'b1;
      end
      lwSp:
      begin
        selM = REG_SP;
        selT = rx;
        selW = 1'b1;
      end
      lw:
      begin
        selM = rx;
        selT = ry;
        selW = 1'b1;
      end
      swSp:
      begin
        selS = rx;
        selM = REG_SP;
      end
      sw:
      begin
        selS = ry;
        selM = rx;
      end
      adduSubu:
      begin
        selS = rx;
        selM = ry;
        selT = rz;
        selW = 1'b1;
      end
      regOp:
        case (instrReg[4:0])
          5'b00000:
            case (instrReg[7:5])
              3'b000: selS = rx;   // jr
              3'b010:              // mfpc
              begin
                selT = rx;
                selW = 1'b1;
              end
              3'b110:              // jalr
              begin
                selS = rx;
                selT = REG_RA;
                selW = 1'b1;
              end
              default: ;           // jrra and reserved
            endcase
          5'b00010, 5'b00011:      // slt, sltu
          begin
            selS = rx;
            selM = ry;
          end
          5'b00100, 5'b00110, 5'b00111: // sllv, srlv, srav
          begin
            selS = ry;
            selM = rx;
            selT = ry;
            selW = 1'b1;
          end
          5'b01010:                // cmp
          begin
            selS = ry;
            selM = rx;
          end
          5'b01011, 5'b01111:      // neg, not
          begin
            selS = ry;
            selT = rx;
            selW = 1'b1;
          end
          5'b01100, 5'b01101, 5'b01110: // and, or, xor
          begin
            selS = ry;
            selM = rx;
            selT = rx;
            selW = 1'b1;
          end
          default: ;
        endcase
      ihOp:
        if (instrReg[0])           // mtih
        begin
          selS = rx;
          selT = REG_IH;
          selW = 1'b1;
        end
        else                       // mfih
        begin
          selS = REG_IH;
          selT = rx;
          selW = 1'b1;
        end
      default: ;                   // nop, b, int, unlisted
    endcase
  end

  // second stage: registered selection record
  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      decoded <= '{op: nop, regS: '0, regM: '0, regT: '0, writeT: 1'b0, valid: 1'b0};
    else
      decoded <= '{op: opcode, regS: selS, regM: selM, regT: selT, writeT: selW,
                   valid: validReg};
  end

  // a strobed word from fetch must be fully known
  strobedWordKnown: assert property (@(posedge clk) disable iff (!rst)
    instrValid |-> !$isunknown(instruction))
    else $error("strobed instruction word has unknown bits");

endmodule

// File: logic/operandFetch.sv
module operandFetch
  import cpuDecodePkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  decodedT     decoded,
  input  logic [15:0] immediate,
  input  logic [15:0] readS,
  input  logic [15:0] readM,
  input  logic        wbEn,
  input  regIndexT    wbIndex,
  input  logic [15:0] wbData,
  output regIndexT    readIndexS,
  output regIndexT    readIndexM,
  output operandT     operands
);

  logic [15:0] immHeld;  // immediate of the instruction now in decoded
  logic [15:0] valueS;
  logic [15:0] valueM;

  assign readIndexS = decoded.regS;
  assign readIndexM = decoded.regM;

  // same-cycle write-back wins over the stored value
  assign valueS = (wbEn && (wbIndex == decoded.regS)) ? wbData : readS;
  assign valueM = (wbEn && (wbIndex == decoded.regM)) ? wbData : readM;

  // immediate is taken from instrReg, one stage ahead of decoded
  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      immHeld <= '0;
    else
      immHeld <= immediate;
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      operands <= '0;
    else
    begin
      operands.decoded   <= decoded;
      operands.valueS    <= valueS;
      operands.valueM    <= valueM;
      operands.immediate <= immHeld;
    end
  end

  // register data or write-back data feeding a valid record must be known
  operandsKnown: assert property (@(posedge clk) disable iff (!rst)
    decoded.valid |-> !$isunknown({valueS, valueM}))
    else $error("unknown operand value for a valid record");

endmodule

// File: logic/registerFile.sv
module registerFile
  import cpuDecodePkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  regIndexT    readIndexS,
  input  regIndexT    readIndexM,
  input  logic        wbEn,
  input  regIndexT    wbIndex,
  input  logic [15:0] wbData,
  output logic [15:0] readS,
  output logic [15:0] readM
);

  logic [15:0] regs [NUM_REGS];  // r0..r7, ih, sp, ra

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      for (int i = 0; i < NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (wbEn && (wbIndex < NUM_REGS))
    begin
      regs[wbIndex] <= wbData;
    end
  end

  // async read, unused indices read as zero
  assign readS = (readIndexS < NUM_REGS) ? regs[readIndexS] : '0;
  assign readM = (readIndexM < NUM_REGS) ? regs[readIndexM] : '0;

  // the write-back source outside this stage must stay inside the register space
  wbIndexRange: assert property (@(posedge clk) disable iff (!rst)
    wbEn |-> (wbIndex < NUM_REGS))
    else $error("write-back index %0d outside register file", wbIndex);

endmodule

// File: runSim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module decodeStageTb -f decodeStage.f -Mdir obj_dir

output=$(./obj_dir/VdecodeStageTb || true)
echo "$output"

if echo "$output" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
